// File: filelist.f
src/shape_pkg.sv
src/sine_table.sv
src/rotate_xy.sv
src/draw_line.sv
src/draw_triangle.sv
src/shape_sequencer.sv
src/shape_top.sv
tests/shape_tb_assert.sv
tests/shape_tb.sv

// File: Bender.yml
package:
  name: shape_engine

sources:
  - src/shape_pkg.sv
  - src/sine_table.sv
  - src/rotate_xy.sv
  - src/draw_line.sv
  - src/draw_triangle.sv
  - src/shape_sequencer.sv
  - src/shape_top.sv
  - target: test
    files:
      - tests/shape_tb_assert.sv
      - tests/shape_tb.sv

// File: tests/shape_tb.sv
// ========================================
// testbench for the rotating triangle
// drawer, table driven with a line model
// ========================================

`timescale 1ns/1ps

module shape_tb;
    import shape_pkg::*;

    localparam int num_rows    = 8;
    localparam int cycle_limit = num_rows * 4000;  // generous per-row budget

    typedef struct packed {
        logic [7:0] inc_cnt;    // angle_inc strobes
        logic [7:0] dec_cnt;    // angle_dec strobes
        logic       stall;      // random fb_busy while drawing
        logic [7:0] exp_angle;
    } row_t;

    // angles walk 0, 10, 248 (wrap below 0), 32 (wrap past 255), 96, 96, 128, 68
    row_t rows [num_rows] = '{
        '{8'd0,  8'd0,  1'b0, 8'd0},
        '{8'd5,  8'd0,  1'b0, 8'd10},
        '{8'd3,  8'd12, 1'b1, 8'd248},
        '{8'd20, 8'd0,  1'b0, 8'd32},
        '{8'd32, 8'd0,  1'b0, 8'd96},
        '{8'd0,  8'd0,  1'b1, 8'd96},   // same angle as above, stalled
        '{8'd16, 8'd0,  1'b1, 8'd128},
        '{8'd0,  8'd30, 1'b0, 8'd68}
    };

    logic      clk_100m;
    logic      rst_n;
    logic      frame;
    logic      angle_inc;
    logic      angle_dec;
    logic      fb_busy;
    logic      fb_we;
    pixel_wr_t fb_wr;
    logic      draw_done;
    angle_t    angle;

    int ref_x[$];       // expected write sequence
    int ref_y[$];
    int vert_x[3];      // rotated, translated vertices
    int vert_y[3];
    int edge_first[3];  // index of each edge's first pixel
    int exp_count;
    int cycles;

    shape_top u_shape_top (
        .clk_100m,
        .rst_n,
        .frame,
        .angle_inc,
        .angle_dec,
        .fb_busy,
        .fb_we,
        .fb_wr,
        .draw_done,
        .angle
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // watchdog, also polls the bound assertions
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk_100m);
            cycles++;
            if (u_shape_top.u_shape_tb_assert.fail_cnt != 0)
                stop_run("a bound assertion on the write port or done pulse failed");
        end
        stop_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
    end

    task automatic stop_run(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(string name, logic signed [31:0] actual,
                         logic signed [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s actual=%0d expected=%0d", $time, name, actual, expected);
            stop_run("first mismatch ends the run");
        end
    endtask

    // round(127 * sin(2 pi a / 256)) with real maths
    function automatic int sin_ref(int a);
        real r;
        r = 127.0 * $sin(2.0 * 3.14159265358979 * real'(a % 256) / 256.0);
        return (r < 0.0) ? -$rtoi(-r + 0.5) : $rtoi(r + 0.5);
    endfunction

    // plain Bresenham, both end points included
    task automatic add_line(int x0, int y0, int x1, int y1);
        int dx;
        int dy;
        int sx;
        int sy;
        int err;
        int e2;
        int x;
        int y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        sx  = (x1 >= x0) ? 1 : -1;
        sy  = (y1 >= y0) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        while (1) begin
            ref_x.push_back(x);
            ref_y.push_back(y);
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
        exp_count += ((dx > -dy) ? dx : -dy) + 1;  // max(|dx|,|dy|) + 1
    endtask

    task automatic build_ref(int ang);
        int bx[3] = '{0, -30, 45};   // unrotated triangle
        int by[3] = '{-40, 20, 70};
        int s;
        int c;
        int nx;
        s = sin_ref(ang);
        c = sin_ref(ang + 64);
        ref_x.delete();
        ref_y.delete();
        exp_count = 0;
        for (int i = 0; i < 3; i++) begin
            vert_x[i] = ((bx[i] * c - by[i] * s) >>> 7) + 160;  // floor shift, then centre
            vert_y[i] = ((bx[i] * s + by[i] * c) >>> 7) + 90;
        end
        for (int e = 0; e < 3; e++) begin
            nx = (e + 1) % 3;
            edge_first[e] = ref_x.size();
            add_line(vert_x[e], vert_y[e], vert_x[nx], vert_y[nx]);
        end
    endtask

    initial begin
        row_t row;
        int   n;
        logic mid_sent;
        void'($urandom(32'h0f59_2934));
        rst_n     = 1'b0;
        frame     = 1'b0;
        angle_inc = 1'b0;
        angle_dec = 1'b0;
        fb_busy   = 1'b0;
        repeat (10) @(negedge clk_100m);
        rst_n = 1'b1;
        repeat (20) begin  // quiet without a frame
            @(negedge clk_100m);
            check("fb_we", fb_we, 0);
            check("draw_done", draw_done, 0);
        end
        check("angle", angle, 0);
        for (int r = 0; r < num_rows; r++) begin
            row = rows[r];
            repeat (row.inc_cnt) begin
                @(negedge clk_100m);
                angle_inc = 1'b1;
                @(negedge clk_100m);
                angle_inc = 1'b0;
            end
            repeat (row.dec_cnt) begin
                @(negedge clk_100m);
                angle_dec = 1'b1;
                @(negedge clk_100m);
                angle_dec = 1'b0;
            end
            repeat (3) @(negedge clk_100m);
            check("angle", angle, row.exp_angle);
            build_ref(row.exp_angle);
            frame    = 1'b1;
            n        = 0;
            mid_sent = 1'b0;
            do begin
                @(negedge clk_100m);
                if (fb_we) begin
                    if (n >= ref_x.size())
                        stop_run("DUT wrote more pixels than the reference line set holds");
                    if (r == 0 && n == 0) begin
                        check("first write x", fb_wr.x, 160);
                        check("first write y", fb_wr.y, 50);
                    end
                    for (int e = 0; e < 3; e++) begin
                        if (n == edge_first[e]) begin
                            check("edge start x", fb_wr.x, vert_x[e]);
                            check("edge start y", fb_wr.y, vert_y[e]);
                        end
                    end
                    check("fb_wr.x", fb_wr.x, ref_x[n]);
                    check("fb_wr.y", fb_wr.y, ref_y[n]);
                    n++;
                end
                frame    = (n == 3) && !mid_sent;  // stray frame mid draw, must be dropped
                mid_sent = mid_sent | frame;
                fb_busy  = row.stall ? 1'($urandom % 2) : 1'b0;
            end while (!draw_done);
            fb_busy = 1'b0;
            frame   = 1'b0;
            check("write count", n, exp_count);
            repeat (20) begin  // no second frame follows
                @(negedge clk_100m);
                check("fb_we", fb_we, 0);
                check("draw_done", draw_done, 0);
            end
        end
        if (u_shape_top.u_shape_tb_assert.fail_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_run("a bound assertion on the write port or done pulse failed");
        end
    end

endmodule

// File: tests/shape_tb_assert.sv
// ========================================
// write port and done pulse assertions
// ========================================

`timescale 1ns/1ps

module shape_tb_assert (
    input wire logic                 clk_100m,
    input wire logic                 rst_n,
    input wire logic                 fb_busy,
    input wire logic                 fb_we,
    input wire shape_pkg::pixel_wr_t fb_wr,
    input wire logic                 draw_done
);
    import shape_pkg::*;

    int fail_cnt = 0;  // assertion failures so far

    // busy blocks the write one cycle later
    a_no_write_after_busy: assert property (@(posedge clk_100m) disable iff (!rst_n)
        $past(fb_busy) |-> !fb_we)
        else begin
            fail_cnt++;
            $error("fb_we high in the cycle after fb_busy");
        end

    a_done_single: assert property (@(posedge clk_100m) disable iff (!rst_n)
        draw_done |=> !draw_done)
        else begin
            fail_cnt++;
            $error("draw_done longer than one cycle");
        end

    a_write_colour: assert property (@(posedge clk_100m) disable iff (!rst_n)
        fb_we |-> (fb_wr.cidx == shape_cidx))  // outline colour only
        else begin
            fail_cnt++;
            $error("fb_wr colour index wrong");
        end

endmodule

bind shape_top shape_tb_assert u_shape_tb_assert (
    .clk_100m,
    .rst_n,
    .fb_busy,
    .fb_we,
    .fb_wr,
    .draw_done
);

// File: src/shape_top.sv
// ========================================
// rotating triangle drawer, framebuffer
// write port out
// ========================================

`timescale 1ns/1ps

module shape_top (
    input  wire logic                 clk_100m,
    input  wire logic                 rst_n,
    input  wire logic                 frame,
    input  wire logic                 angle_inc,
    input  wire logic                 angle_dec,
    input  wire logic                 fb_busy,
    output      logic                 fb_we,
    output      shape_pkg::pixel_wr_t fb_wr,
    output      logic                 draw_done,
    output      shape_pkg::angle_t    angle
);
    import shape_pkg::*;

    logic    rot_start;
    logic    rot_done;
    angle_t  rot_angle;
    vertex_t rot_in;
    vertex_t rot_out;
    logic    tri_start;
    logic    tri_done;
    vertex_t v0;
    vertex_t v1;
    vertex_t v2;
    vertex_t pix;
    logic    drawing;

    shape_sequencer u_shape_sequencer (
        .clk_100m,
        .rst_n,
        .frame,
        .angle_inc,
        .angle_dec,
        .angle,
        .rot_start,
        .rot_angle,
        .rot_in,
        .rot_out,
        .rot_done,
        .tri_start,
        .v0,
        .v1,
        .v2,
        .tri_done
    );

    rotate_xy u_rotate_xy (
        .clk_100m,
        .rst_n,
        .start (rot_start),
        .angle (rot_angle),
        .vin   (rot_in),
        .vout  (rot_out),
        .done  (rot_done)
    );

    draw_triangle u_draw_triangle (
        .clk_100m,
        .rst_n,
        .start   (tri_start),
        .oe      (!fb_busy),  // stall while the framebuffer is busy
        .v0,
        .v1,
        .v2,
        .pix,
        .drawing,
        .done    (tri_done)
    );

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            fb_we     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            fb_we     <= drawing;   // one cycle behind the drawer
            draw_done <= tri_done;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (drawing) fb_wr <= '{x: pix.x, y: pix.y, cidx: shape_cidx};
    end

endmodule

// File: src/shape_sequencer.sv
// ========================================
// per-frame sequencer with angle register
// rotate, translate, then draw
// ========================================

`timescale 1ns/1ps

module shape_sequencer (
    input  wire logic               clk_100m,
    input  wire logic               rst_n,
    input  wire logic               frame,
    input  wire logic               angle_inc,
    input  wire logic               angle_dec,
    output      shape_pkg::angle_t  angle,
    output      logic               rot_start,
    output      shape_pkg::angle_t  rot_angle,
    output      shape_pkg::vertex_t rot_in,
    input  wire shape_pkg::vertex_t rot_out,
    input  wire logic               rot_done,
    output      logic               tri_start,
    output      shape_pkg::vertex_t v0,
    output      shape_pkg::vertex_t v1,
    output      shape_pkg::vertex_t v2,
    input  wire logic               tri_done
);
    import shape_pkg::*;

    typedef enum logic [1:0] {s_idle, s_feed, s_collect, s_draw} state_t;
    state_t state;

    logic [1:0] feed_cnt;  // next vertex into the rotator
    logic [1:0] res_cnt;   // next result back
    vertex_t    rot_trans;

    // angle steps by 2, wraps mod 256, both strobes cancel
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            angle <= '0;
        end else if (angle_inc && !angle_dec) begin
            angle <= angle + angle_step;
        end else if (angle_dec && !angle_inc) begin
            angle <= angle - angle_step;
        end
    end

    always_comb begin
        rot_trans.x = rot_out.x + shape_offs.x;  // move to screen centre
        rot_trans.y = rot_out.y + shape_offs.y;
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state     <= s_idle;
            rot_start <= 1'b0;
            tri_start <= 1'b0;
            feed_cnt  <= 2'd0;
            res_cnt   <= 2'd0;
        end else begin
            rot_start <= 1'b0;
            tri_start <= 1'b0;
            case (state)
                s_idle: if (frame) begin  // frames while busy are dropped
                    rot_start <= 1'b1;    // v0
                    feed_cnt  <= 2'd1;
                    res_cnt   <= 2'd0;
                    state     <= s_feed;
                end
                s_feed: begin
                    rot_start <= 1'b1;  // v1, then v2
                    feed_cnt  <= feed_cnt + 2'd1;
                    if (feed_cnt == 2'd2) state <= s_collect;
                end
                s_collect: if (rot_done) begin
                    res_cnt <= res_cnt + 2'd1;
                    if (res_cnt == 2'd2) begin
                        tri_start <= 1'b1;
                        state     <= s_draw;
                    end
                end
                s_draw: if (tri_done) state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == s_idle && frame) begin
            rot_angle <= angle;  // held for the whole frame
            rot_in    <= shape_v0;
        end else if (state == s_feed) begin
            rot_in <= (feed_cnt == 2'd1) ? shape_v1 : shape_v2;
        end
        if (state == s_collect && rot_done) begin
            case (res_cnt)
                2'd0:    v0 <= rot_trans;
                2'd1:    v1 <= rot_trans;
                default: v2 <= rot_trans;
            endcase
        end
    end

endmodule

// File: src/draw_triangle.sv
// ========================================
// triangle outline as three line runs
// ========================================

`timescale 1ns/1ps

module draw_triangle (
    input  wire logic               clk_100m,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               oe,
    input  wire shape_pkg::vertex_t v0,
    input  wire shape_pkg::vertex_t v1,
    input  wire shape_pkg::vertex_t v2,
    output      shape_pkg::vertex_t pix,
    output      logic               drawing,
    output      logic               done
);
    import shape_pkg::*;

    typedef enum logic {s_idle, s_draw} state_t;
    state_t state;

    logic [1:0] edge_idx;  // 0: v0-v1, 1: v1-v2, 2: v2-v0
    logic       line_start;
    logic       line_done;
    vertex_t    lp0;
    vertex_t    lp1;

    always_comb begin
        case (edge_idx)
            2'd0:    begin lp0 = v0; lp1 = v1; end
            2'd1:    begin lp0 = v1; lp1 = v2; end
            default: begin lp0 = v2; lp1 = v0; end  // closing edge
        endcase
    end

    draw_line u_draw_line (
        .clk_100m,
        .rst_n,
        .start   (line_start),
        .oe,
        .p0      (lp0),
        .p1      (lp1),
        .pix,
        .drawing,
        .done    (line_done)
    );

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state      <= s_idle;
            edge_idx   <= 2'd0;
            line_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                s_idle: if (start) begin
                    edge_idx   <= 2'd0;
                    line_start <= 1'b1;
                    state      <= s_draw;
                end
                s_draw: if (line_done) begin
                    if (edge_idx == 2'd2) begin
                        done  <= 1'b1;  // outline closed
                        state <= s_idle;
                    end else begin
                        edge_idx   <= edge_idx + 2'd1;
                        line_start <= 1'b1;  // next edge, mux already follows
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: src/draw_line.sv
// ========================================
// Bresenham line, any octant, one pixel
// per cycle while oe is high
// ========================================

`timescale 1ns/1ps

module draw_line (
    input  wire logic               clk_100m,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               oe,
    input  wire shape_pkg::vertex_t p0,
    input  wire shape_pkg::vertex_t p1,
    output      shape_pkg::vertex_t pix,
    output      logic               drawing,
    output      logic               done
);
    import shape_pkg::*;

    localparam int ew = cordw + 3;  // error term, room for 2*err

    typedef enum logic {s_idle, s_draw} state_t;
    state_t state;

    vertex_t               p_end;  // last pixel of the line
    logic signed [cordw:0] ddx;    // raw deltas
    logic signed [cordw:0] ddy;
    logic signed [ew-1:0]  dx_in;
    logic signed [ew-1:0]  dy_in;
    logic                  sx_in;  // 1 steps towards negative
    logic                  sy_in;
    logic signed [ew-1:0]  dx;     // |dx|
    logic signed [ew-1:0]  dy;     // -|dy|
    logic signed [ew-1:0]  err;
    logic signed [ew-1:0]  e2;
    logic                  sx;
    logic                  sy;
    coord_t                stepx;
    coord_t                stepy;
    logic                  movx;
    logic                  movy;
    logic                  last;

    // setup values straight from the end points
    always_comb begin
        ddx   = p1.x - p0.x;
        ddy   = p1.y - p0.y;
        sx_in = (ddx < 0);
        sy_in = (ddy < 0);
        dx_in = sx_in ? -ddx : ddx;
        dy_in = sy_in ? ddy : -ddy;  // kept negative
    end

    always_comb begin
        e2      = err <<< 1;
        movx    = (e2 >= dy);
        movy    = (e2 <= dx);
        stepx   = sx ? coord_t'(-1) : coord_t'(1);
        stepy   = sy ? coord_t'(-1) : coord_t'(1);
        last    = (pix == p_end);  // both end points drawn
        drawing = (state == s_draw) && oe;
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: if (start) state <= s_draw;
                s_draw: if (drawing && last) begin
                    state <= s_idle;
                    done  <= 1'b1;  // cycle after the final pixel
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == s_idle && start) begin
            pix   <= p0;
            p_end <= p1;
            dx    <= dx_in;
            dy    <= dy_in;
            sx    <= sx_in;
            sy    <= sy_in;
            err   <= dx_in + dy_in;
        end else if (drawing && !last) begin  // holds while oe is low
            err <= err + (movx ? dy : '0) + (movy ? dx : '0);
            if (movx) pix.x <= pix.x + stepx;
            if (movy) pix.y <= pix.y + stepy;
        end
    end

endmodule

// File: src/rotate_xy.sv
// ========================================
// vertex rotation, 3 stage pipeline
// ========================================

`timescale 1ns/1ps

module rotate_xy (
    input  wire logic               clk_100m,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire shape_pkg::angle_t  angle,
    input  wire shape_pkg::vertex_t vin,
    output      shape_pkg::vertex_t vout,
    output      logic               done
);
    import shape_pkg::*;

    localparam int prodw = cordw + 8;  // coord times q7 sine

    logic signed [7:0] sin_val;
    logic signed [7:0] cos_val;
    vertex_t           v1;  // vin delayed to line up with the lookup
    logic              valid1;
    logic              valid2;

    // stage 2 products
    logic signed [prodw-1:0] xc;
    logic signed [prodw-1:0] ys;
    logic signed [prodw-1:0] xs;
    logic signed [prodw-1:0] yc;

    // stage 3 sums, one guard bit
    logic signed [prodw:0] rx;
    logic signed [prodw:0] ry;

    // stage 1 is the registered lookup
    sine_table u_sine_table (
        .clk_100m,
        .rst_n,
        .angle,
        .sin_val,
        .cos_val
    );

    // valid travels with the data, so starts can go back to back
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            done   <= 1'b0;
        end else begin
            valid1 <= start;
            valid2 <= valid1;
            done   <= valid2;  // 3 cycles after start
        end
    end

    always_comb begin
        rx = xc - ys;  // x cos - y sin
        ry = xs + yc;  // x sin + y cos
    end

    always_ff @(posedge clk_100m) begin
        v1 <= vin;                      // stage 1
        xc <= v1.x * cos_val;           // stage 2
        ys <= v1.y * sin_val;
        xs <= v1.x * sin_val;
        yc <= v1.y * cos_val;
        vout.x <= coord_t'(rx >>> sin_frac);  // stage 3, back to integer
        vout.y <= coord_t'(ry >>> sin_frac);
    end

endmodule

// File: src/sine_table.sv
// ========================================
// sine and cosine lookup, 8-bit angle,
// q7 outputs registered, 1 cycle latency
// ========================================

`timescale 1ns/1ps

module sine_table (
    input  wire logic              clk_100m,
    input  wire logic              rst_n,
    input  wire shape_pkg::angle_t angle,
    output      logic signed [7:0] sin_val,
    output      logic signed [7:0] cos_val
);
    import shape_pkg::*;

    logic signed [7:0] rom [64];  // first quarter, 0 up to just below 90 deg
    angle_t            cos_angle;

    // rom contents fixed at elaboration
    for (genvar i = 0; i < 64; i++) begin : g_rom
        assign rom[i] = sin_q7(angle_t'(i));
    end

    // mirror for quarters 1 and 3, negate for 2 and 3
    function automatic logic signed [7:0] full_wave(input angle_t a);
        logic [6:0]        idx;
        logic signed [7:0] mag;
        idx = a[6] ? 7'd64 - {1'b0, a[5:0]} : {1'b0, a[5:0]};
        mag = idx[6] ? 8'sd127 : rom[idx[5:0]];  // 90 deg lies past the rom
        return a[7] ? -mag : mag;
    endfunction

    assign cos_angle = angle + angle_t'(64);  // cos(a) = sin(a + 90 deg)

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            sin_val <= '0;
            cos_val <= '0;
        end else begin
            sin_val <= full_wave(angle);
            cos_val <= full_wave(cos_angle);
        end
    end

endmodule

// File: src/shape_pkg.sv
// ========================================
// shape engine shared types, constants
// and the quarter-wave sine rule
// ========================================

package shape_pkg;

    localparam int cordw    = 16;  // coordinate width
    localparam int anglew   = 8;   // 256 steps per full turn
    localparam int cidxw    = 4;   // colour index width
    localparam int sin_frac = 7;   // sine values are q7

    typedef logic signed [cordw-1:0] coord_t;
    typedef logic [anglew-1:0] angle_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // single framebuffer write
    typedef struct packed {
        coord_t           x;
        coord_t           y;
        logic [cidxw-1:0] cidx;
    } pixel_wr_t;

    // triangle around the origin, before rotation
    localparam vertex_t shape_v0   = '{x: coord_t'(0),   y: coord_t'(-40)};
    localparam vertex_t shape_v1   = '{x: coord_t'(-30), y: coord_t'(20)};
    localparam vertex_t shape_v2   = '{x: coord_t'(45),  y: coord_t'(70)};
    localparam vertex_t shape_offs = '{x: coord_t'(160), y: coord_t'(90)};  // screen centre

    localparam logic [cidxw-1:0] shape_cidx = 4'h8;  // outline colour
    localparam angle_t           angle_step = 8'd2;  // per strobe

    // round(127 * sin) over the first quarter, 0 to 90 deg inclusive
    localparam logic [6:0] sin_quarter [65] = '{
          0,   3,   6,   9,  12,  16,  19,  22,
         25,  28,  31,  34,  37,  40,  43,  46,
         49,  51,  54,  57,  60,  63,  65,  68,
         71,  73,  76,  78,  81,  83,  85,  88,
         90,  92,  94,  96,  98, 100, 102, 104,
        106, 107, 109, 111, 112, 113, 115, 116,
        117, 118, 120, 121, 122, 122, 123, 124,
        125, 125, 126, 126, 126, 127, 127, 127,
        127
    };

    // full-turn sine in q7, mirrored and negated from the quarter table
    function automatic logic signed [7:0] sin_q7(input angle_t a);
        logic [6:0]        idx;
        logic signed [7:0] mag;
        idx = a[6] ? 7'd64 - {1'b0, a[5:0]} : {1'b0, a[5:0]};  // 2nd/4th quarter mirror
        mag = signed'({1'b0, sin_quarter[idx]});
        return a[7] ? -mag : mag;  // lower half negative
    endfunction

endpackage
